//--- logic/madd_settings.svh
`ifndef MADD_SETTINGS_SVH
`define MADD_SETTINGS_SVH

// Operand width of a, b and c.
`define MADD_DATA_WIDTH 16

// Product, sum and result width.
`define MADD_FULL_WIDTH 40

// Right-shift amount, 0 to 15.
`define MADD_SHIFT_WIDTH 4

// Destination tag that travels with each item.
`define MADD_DEST_WIDTH 4

// Signed range that saturation clamps to.
`define MADD_SAT_WIDTH 32

`endif

//--- logic/madd_pkg.sv
`include "madd_settings.svh"

package madd_pkg;

	typedef logic signed [`MADD_DATA_WIDTH-1:0] operand_t;
	typedef logic signed [`MADD_FULL_WIDTH-1:0] wide_t;
	typedef logic [`MADD_SHIFT_WIDTH-1:0] shift_t;
	typedef logic [`MADD_DEST_WIDTH-1:0] dest_t;

	typedef struct packed {
		wide_t    product;
		operand_t arg_c;
		shift_t   shift;
		logic     shift_disable;
		logic     signedness;
		logic     saturate_disable;
		dest_t    dest;
	} product_stage_t;

	// Product after the coarse shift, rounding still pending.
	typedef struct packed {
		wide_t    product;
		operand_t arg_c;
		shift_t   shift;
		logic     shift_disable;
		logic     signedness;
		logic     saturate_disable;
		logic     rounding_bit;
		dest_t    dest;
	} shifted_stage_t;

	typedef struct packed {
		wide_t    product;
		operand_t arg_c;
		logic     signedness;
		logic     saturate_disable;
		dest_t    dest;
	} sum_stage_t;

	typedef struct packed {
		wide_t sum;
		logic  saturate_disable;
		dest_t dest;
	} add_stage_t;

	typedef struct packed {
		wide_t result;
		dest_t dest;
	} result_stage_t;

endpackage

//--- logic/madd_stage_register.sv
`timescale 1ns/10ps

module madd_stage_register #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic take_in;
	logic take_out;

	// Room when empty, or when the held item leaves this cycle.
	assign in_ready = !out_valid || out_ready;
	assign take_in = in_valid && in_ready;
	assign take_out = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (take_in) begin
			out_valid <= 1'b1;
		end else if (take_out) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			out_data <= in_data;
		end
	end

	reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid);

	// A stalled item must be held unchanged until the consumer takes it.
	held_item_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- logic/madd_multiply.sv
`timescale 1ns/10ps

module madd_multiply (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  madd_pkg::operand_t       arg_a,
	input  madd_pkg::operand_t       arg_b,
	input  madd_pkg::operand_t       arg_c,
	input  madd_pkg::shift_t         shift,
	input  logic                     shift_disable,
	input  logic                     signedness,
	input  logic                     saturate_disable,
	input  madd_pkg::dest_t          dest,
	output logic                     out_valid,
	input  logic                     out_ready,
	output madd_pkg::product_stage_t out_data
);

	madd_pkg::wide_t signed_product;
	madd_pkg::wide_t unsigned_product;
	madd_pkg::product_stage_t product_next;

	// Both operands are widened to 40 bits before the multiply.
	assign signed_product = arg_a * arg_b;
	assign unsigned_product = $unsigned(arg_a) * $unsigned(arg_b);

	always_comb begin
		product_next.product = signedness ? signed_product : unsigned_product;
		product_next.arg_c = arg_c;
		product_next.shift = shift;
		product_next.shift_disable = shift_disable;
		product_next.signedness = signedness;
		product_next.saturate_disable = saturate_disable;
		product_next.dest = dest;
	end

	madd_stage_register #(
		.payload_t(madd_pkg::product_stage_t)
	) product_reg (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(product_next),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

//--- logic/madd_round_shift.sv
`timescale 1ns/10ps

module madd_round_shift (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  madd_pkg::product_stage_t in_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output madd_pkg::sum_stage_t     out_data
);

	madd_pkg::wide_t product_in;
	madd_pkg::wide_t coarse_8;
	madd_pkg::wide_t coarse_4;
	madd_pkg::shift_t round_index;
	madd_pkg::shifted_stage_t shifted_next;

	logic shifted_valid;
	logic shifted_ready;
	madd_pkg::shifted_stage_t shifted_data;

	madd_pkg::wide_t shifted_product;
	madd_pkg::wide_t fine_2;
	madd_pkg::wide_t fine_1;
	madd_pkg::sum_stage_t sum_next;

	assign product_in = in_data.product;

	// Coarse stage handles shift bits 3 and 2.
	assign coarse_8 = in_data.shift[3] ? (product_in >>> 8) : product_in;
	assign coarse_4 = in_data.shift[2] ? (coarse_8 >>> 4) : coarse_8;

	// Last bit shifted out; wraps to 15 for a zero shift, which is masked below.
	assign round_index = in_data.shift - 1'b1;

	always_comb begin
		shifted_next.product = in_data.shift_disable ? product_in : coarse_4;
		shifted_next.arg_c = in_data.arg_c;
		shifted_next.shift = in_data.shift;
		shifted_next.shift_disable = in_data.shift_disable;
		shifted_next.signedness = in_data.signedness;
		shifted_next.saturate_disable = in_data.saturate_disable;
		shifted_next.rounding_bit = product_in[round_index] && (in_data.shift != '0)
			&& !in_data.shift_disable;
		shifted_next.dest = in_data.dest;
	end

	madd_stage_register #(
		.payload_t(madd_pkg::shifted_stage_t)
	) coarse_reg (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(shifted_next),
		.out_valid(shifted_valid),
		.out_ready(shifted_ready),
		.out_data(shifted_data)
	);

	assign shifted_product = shifted_data.product;

	// Fine stage handles shift bits 1 and 0, then rounds half up.
	assign fine_2 = shifted_data.shift[1] ? (shifted_product >>> 2) : shifted_product;
	assign fine_1 = shifted_data.shift[0] ? (fine_2 >>> 1) : fine_2;

	always_comb begin
		if (shifted_data.shift_disable) begin
			sum_next.product = shifted_product;
		end else begin
			sum_next.product = fine_1 + shifted_data.rounding_bit;
		end
		sum_next.arg_c = shifted_data.arg_c;
		sum_next.signedness = shifted_data.signedness;
		sum_next.saturate_disable = shifted_data.saturate_disable;
		sum_next.dest = shifted_data.dest;
	end

	madd_stage_register #(
		.payload_t(madd_pkg::sum_stage_t)
	) fine_reg (
		.clk(clk),
		.reset(reset),
		.in_valid(shifted_valid),
		.in_ready(shifted_ready),
		.in_data(sum_next),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

//--- logic/madd_accumulate.sv
`timescale 1ns/10ps

`include "madd_settings.svh"

module madd_accumulate (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  madd_pkg::sum_stage_t in_data,
	output logic                 out_valid,
	input  logic                 out_ready,
	output madd_pkg::add_stage_t out_data
);

	logic c_fill;
	madd_pkg::wide_t c_wide;
	madd_pkg::add_stage_t add_next;

	// Sign bit of c only counts for signed operation.
	assign c_fill = in_data.signedness && in_data.arg_c[`MADD_DATA_WIDTH-1];
	assign c_wide = {{(`MADD_FULL_WIDTH - `MADD_DATA_WIDTH){c_fill}}, in_data.arg_c};

	always_comb begin
		add_next.sum = in_data.product + c_wide;
		add_next.saturate_disable = in_data.saturate_disable;
		add_next.dest = in_data.dest;
	end

	madd_stage_register #(
		.payload_t(madd_pkg::add_stage_t)
	) add_reg (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(add_next),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

//--- logic/madd_saturate.sv
`timescale 1ns/10ps

`include "madd_settings.svh"

module madd_saturate (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  madd_pkg::add_stage_t in_data,
	output logic                 out_valid,
	input  logic                 out_ready,
	output madd_pkg::wide_t      result,
	output madd_pkg::dest_t      dest_out
);

	// Limits of the 32-bit signed range, held at full width.
	localparam madd_pkg::wide_t sat_max =
		{{(`MADD_FULL_WIDTH - `MADD_SAT_WIDTH + 1){1'b0}}, {(`MADD_SAT_WIDTH - 1){1'b1}}};
	localparam madd_pkg::wide_t sat_min =
		{{(`MADD_FULL_WIDTH - `MADD_SAT_WIDTH + 1){1'b1}}, {(`MADD_SAT_WIDTH - 1){1'b0}}};

	madd_pkg::wide_t sum_in;
	madd_pkg::wide_t clamped;
	madd_pkg::result_stage_t result_next;
	madd_pkg::result_stage_t result_data;

	assign sum_in = in_data.sum;

	always_comb begin
		if (sum_in > sat_max) begin
			clamped = sat_max;
		end else if (sum_in < sat_min) begin
			clamped = sat_min;
		end else begin
			clamped = sum_in;
		end
		result_next.result = in_data.saturate_disable ? sum_in : clamped;
		result_next.dest = in_data.dest;
	end

	madd_stage_register #(
		.payload_t(madd_pkg::result_stage_t)
	) result_reg (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(result_next),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(result_data)
	);

	assign result = result_data.result;
	assign dest_out = result_data.dest;

	result_in_range: assert property (@(posedge clk) disable iff (reset)
		in_valid && in_ready && !in_data.saturate_disable
		|=> result >= sat_min && result <= sat_max);

endmodule

//--- logic/madd_pipeline.sv
`timescale 1ns/10ps

module madd_pipeline (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  madd_pkg::operand_t arg_a,
	input  madd_pkg::operand_t arg_b,
	input  madd_pkg::operand_t arg_c,
	input  madd_pkg::shift_t   shift,
	input  logic               shift_disable,
	input  logic               signedness,
	input  logic               saturate_disable,
	input  madd_pkg::dest_t    dest,
	output logic               out_valid,
	input  logic               out_ready,
	output madd_pkg::wide_t    result,
	output madd_pkg::dest_t    dest_out
);

	logic product_valid;
	logic product_ready;
	madd_pkg::product_stage_t product_data;

	logic sum_valid;
	logic sum_ready;
	madd_pkg::sum_stage_t sum_data;

	logic add_valid;
	logic add_ready;
	madd_pkg::add_stage_t add_data;

	madd_multiply multiply_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.shift(shift),
		.shift_disable(shift_disable),
		.signedness(signedness),
		.saturate_disable(saturate_disable),
		.dest(dest),
		.out_valid(product_valid),
		.out_ready(product_ready),
		.out_data(product_data)
	);

	// Two register stages inside.
	madd_round_shift round_shift_i (
		.clk(clk),
		.reset(reset),
		.in_valid(product_valid),
		.in_ready(product_ready),
		.in_data(product_data),
		.out_valid(sum_valid),
		.out_ready(sum_ready),
		.out_data(sum_data)
	);

	madd_accumulate accumulate_i (
		.clk(clk),
		.reset(reset),
		.in_valid(sum_valid),
		.in_ready(sum_ready),
		.in_data(sum_data),
		.out_valid(add_valid),
		.out_ready(add_ready),
		.out_data(add_data)
	);

	madd_saturate saturate_i (
		.clk(clk),
		.reset(reset),
		.in_valid(add_valid),
		.in_ready(add_ready),
		.in_data(add_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.dest_out(dest_out)
	);

endmodule

//--- tests/madd_checker.sv
`timescale 1ns/10ps

`include "madd_settings.svh"

module madd_checker (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	input  logic               in_ready,
	input  madd_pkg::operand_t arg_a,
	input  madd_pkg::operand_t arg_b,
	input  madd_pkg::operand_t arg_c,
	input  madd_pkg::shift_t   shift,
	input  logic               shift_disable,
	input  logic               signedness,
	input  logic               saturate_disable,
	input  madd_pkg::dest_t    dest,
	input  logic               out_valid,
	input  logic               out_ready,
	input  madd_pkg::wide_t    result,
	input  madd_pkg::dest_t    dest_out,
	output int                 mismatch_count,
	output int                 pending,
	output int                 last_latency
);

	logic [`MADD_FULL_WIDTH-1:0] expected_q[$];
	madd_pkg::dest_t dest_q[$];
	int stamp_q[$];
	int cycle;
	logic [`MADD_FULL_WIDTH-1:0] want_result;
	madd_pkg::dest_t want_dest;

	function automatic logic [`MADD_FULL_WIDTH-1:0] expected_result(
		input logic [`MADD_DATA_WIDTH-1:0] a, b, c,
		input logic [`MADD_SHIFT_WIDTH-1:0] s,
		input logic sd, sg, satd);
		longint pa;
		longint pb;
		longint pc;
		longint value;
		longint sat_hi;
		longint sat_lo;
		sat_hi = (longint'(1) << (`MADD_SAT_WIDTH - 1)) - 1;
		sat_lo = -(longint'(1) << (`MADD_SAT_WIDTH - 1));
		if (sg) begin
			pa = longint'($signed(a));
			pb = longint'($signed(b));
			pc = longint'($signed(c));
		end else begin
			pa = longint'(a);
			pb = longint'(b);
			pc = longint'(c);
		end
		value = pa * pb;
		// Round half up by adding half a step before the floor.
		if (!sd && s != 0)
			value = (value + (longint'(1) << (s - 1))) >>> s;
		value = value + pc;
		if (!satd && value > sat_hi)
			value = sat_hi;
		if (!satd && value < sat_lo)
			value = sat_lo;
		return value[`MADD_FULL_WIDTH-1:0];
	endfunction

	initial begin
		mismatch_count = 0;
		pending = 0;
		last_latency = 0;
		cycle = 0;
	end

	always @(posedge clk) begin
		cycle++;
		if (!reset && out_valid && out_ready) begin
			if (expected_q.size() == 0) begin
				$display("Result %h with dest %0d came out at %0t with nothing sent for it",
					result, dest_out, $time);
				mismatch_count++;
			end else begin
				want_result = expected_q.pop_front();
				want_dest = dest_q.pop_front();
				last_latency = cycle - stamp_q.pop_front();
				if (result !== want_result || dest_out !== want_dest) begin
					$display("CHECK FAILED at %0t: result %h, expected %h, dest %0d, expected %0d",
						$time, result, want_result, dest_out, want_dest);
					mismatch_count++;
				end
			end
		end
		if (!reset && in_valid && in_ready) begin
			expected_q.push_back(expected_result(arg_a, arg_b, arg_c, shift, shift_disable,
				signedness, saturate_disable));
			dest_q.push_back(dest);
			stamp_q.push_back(cycle);
		end
		pending = expected_q.size();
	end

	task automatic report_queue(output int lost);
		lost = expected_q.size();
		if (lost == 0)
			$display("Result queue is empty at the end of the run");
		else
			$display("%0d results were lost: sent in but never came out", lost);
	endtask

endmodule

//--- tests/madd_tb.sv
`timescale 1ns/10ps

`include "madd_settings.svh"

module madd_tb;

	localparam int clock_period = 40;
	localparam int seed = 67;
	localparam int stream_len = 20;
	localparam int random_len = 300;
	localparam int item_count = 16 + 61 + 6 + 1 + stream_len + random_len;
	localparam int cycle_limit = 4 * item_count + 200;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic in_ready;
	madd_pkg::operand_t arg_a;
	madd_pkg::operand_t arg_b;
	madd_pkg::operand_t arg_c;
	madd_pkg::shift_t shift;
	logic shift_disable;
	logic signedness;
	logic saturate_disable;
	madd_pkg::dest_t dest;
	logic out_valid;
	logic out_ready;
	madd_pkg::wide_t result;
	madd_pkg::dest_t dest_out;

	int mismatch_count;
	int pending;
	int last_latency;
	int errors;
	int errors_seen;
	int pass_count;
	int fail_count;
	int stalls;
	int cycles;
	int lost;
	int half;
	int seed_draw;
	logic random_ready;

	// Each pair goes in once signed and once unsigned.
	logic [`MADD_DATA_WIDTH-1:0] prod_a [8] = '{16'd3, 16'hffff, 16'h8000, 16'h7fff,
		16'hfff9, 16'h8000, 16'h1234, 16'h0};
	logic [`MADD_DATA_WIDTH-1:0] prod_b [8] = '{16'd5, 16'hffff, 16'h8000, 16'hfffe,
		16'd9, 16'd1, 16'h00ff, 16'h4321};
	// Signed products never reach -2^31, so only the upper limit can clamp.
	logic [`MADD_DATA_WIDTH-1:0] sat_a [6] = '{16'hffff, 16'hffff, 16'hc000, 16'hb505,
		16'h8000, 16'h8000};
	logic [`MADD_DATA_WIDTH-1:0] sat_b [6] = '{16'hffff, 16'hffff, 16'hc000, 16'hb505,
		16'h8000, 16'h7fff};
	logic [`MADD_DATA_WIDTH-1:0] sat_c [6] = '{16'h0, 16'h0, 16'h0, 16'h0, 16'h7fff, 16'h8000};
	logic [5:0] sat_signed = 6'b100000;
	logic [5:0] sat_off = 6'b000010;

	madd_pipeline madd_pipeline_i (.*);

	madd_checker checker_i (.*);

	initial begin
		forever #(clock_period / 2) clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	always @(negedge clk) begin
		out_ready = random_ready ? ($urandom % 4 != 0) : 1'b1;
	end

	task automatic send_item(input logic [`MADD_DATA_WIDTH-1:0] a, b, c,
		input logic [`MADD_SHIFT_WIDTH-1:0] s, input logic sd, sg, satd);
		@(negedge clk);
		in_valid = 1'b1;
		arg_a = a;
		arg_b = b;
		arg_c = c;
		shift = s;
		shift_disable = sd;
		signedness = sg;
		saturate_disable = satd;
		dest = dest + 1'b1;
		@(posedge clk);
		while (!in_ready) begin
			stalls++;
			@(posedge clk);
		end
	endtask

	task automatic idle_and_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		in_valid = 1'b0;
		while (pending != 0 && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (pending != 0) begin
			$display("%0d results did not come out of the pipeline in time", pending);
			errors++;
		end
	endtask

	task automatic expect_value(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		int total;
		total = errors + mismatch_count;
		$display("Test %s: %s with %0d errors", name,
			total == errors_seen ? "passed" : "failed", total - errors_seen);
		if (total == errors_seen)
			pass_count++;
		else
			fail_count++;
		errors_seen = total;
	endtask

	initial begin
		seed_draw = $urandom(seed);
		reset = 1'b1;
		in_valid = 1'b0;
		arg_a = '0;
		arg_b = '0;
		arg_c = '0;
		shift = '0;
		shift_disable = 1'b0;
		signedness = 1'b0;
		saturate_disable = 1'b0;
		dest = '0;
		out_ready = 1'b1;
		random_ready = 1'b0;
		errors = 0;
		errors_seen = 0;
		pass_count = 0;
		fail_count = 0;
		stalls = 0;

		repeat (10) begin
			@(negedge clk);
			expect_value("out_valid in reset", out_valid, 0);
			expect_value("in_ready in reset", in_ready, 1);
		end
		reset = 1'b0;
		@(negedge clk);
		expect_value("out_valid after reset", out_valid, 0);
		expect_value("in_ready after reset", in_ready, 1);
		finish_test("reset");

		for (int i = 0; i < 8; i++) begin
			send_item(prod_a[i], prod_b[i], 16'd0, 4'd0, 1'b1, 1'b1, 1'b1);
			send_item(prod_a[i], prod_b[i], 16'd0, 4'd0, 1'b1, 1'b0, 1'b1);
		end
		idle_and_drain();
		finish_test("products");

		// Dropped bits just below half and at half, positive and negative.
		for (int s = 1; s < 16; s++) begin
			half = 1 << (s - 1);
			send_item(half - 1, 16'd1, 16'd0, s, 1'b0, 1'b1, 1'b0);
			send_item(half, 16'd1, 16'd0, s, 1'b0, 1'b1, 1'b0);
			send_item(-half, 16'd1, 16'd0, s, 1'b0, 1'b1, 1'b0);
			send_item(-half - 1, 16'd1, 16'd0, s, 1'b0, 1'b1, 1'b0);
		end
		send_item(16'd12345, 16'd3, 16'd0, 4'd0, 1'b0, 1'b1, 1'b0);
		idle_and_drain();
		finish_test("rounding");

		for (int i = 0; i < 6; i++)
			send_item(sat_a[i], sat_b[i], sat_c[i], 4'd0, 1'b1, sat_signed[i], sat_off[i]);
		idle_and_drain();
		finish_test("saturation");

		send_item(16'd100, 16'd200, 16'd7, 4'd3, 1'b0, 1'b1, 1'b0);
		idle_and_drain();
		expect_value("latency", last_latency, 5);
		finish_test("latency");

		stalls = 0;
		for (int i = 0; i < stream_len; i++)
			send_item(i * 977, i + 1, i, i % 16, 1'b0, i % 2, 1'b0);
		idle_and_drain();
		expect_value("stall cycles in stream", stalls, 0);
		finish_test("stream");

		random_ready = 1'b1;
		for (int i = 0; i < random_len; i++) begin
			if ($urandom % 4 == 0) begin
				@(negedge clk);
				in_valid = 1'b0;
			end
			send_item($urandom, $urandom, $urandom, $urandom, $urandom % 4 == 0, $urandom,
				$urandom % 4 == 0);
		end
		idle_and_drain();
		random_ready = 1'b0;
		finish_test("backpressure");

		checker_i.report_queue(lost);
		errors = errors + lost;
		finish_test("final queue");

		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- madd.f
+incdir+logic
logic/madd_pkg.sv
logic/madd_stage_register.sv
logic/madd_multiply.sv
logic/madd_round_shift.sv
logic/madd_accumulate.sv
logic/madd_saturate.sv
logic/madd_pipeline.sv
tests/madd_checker.sv
tests/madd_tb.sv

//--- Bender.yml
package:
  name: madd

sources:
  - include_dirs:
      - logic
    files:
      - logic/madd_pkg.sv
      - logic/madd_stage_register.sv
      - logic/madd_multiply.sv
      - logic/madd_round_shift.sv
      - logic/madd_accumulate.sv
      - logic/madd_saturate.sv
      - logic/madd_pipeline.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/madd_checker.sv
      - tests/madd_tb.sv
